//--- sim.f
+incdir+sim
src/ntt_pkg.sv
src/ntt_mod_mult.sv
src/ntt_butterfly.sv
src/ntt_ready_ctrl.sv
src/ntt_butterfly_2x2.sv
sim/tb_ntt_butterfly_2x2.sv

//--- run.sh
#!/bin/sh
# build and run the 2x2 butterfly testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_ntt_butterfly_2x2 -f sim.f

# the simulation exits non-zero on error, the search below decides
out=$(./obj_dir/Vtb_ntt_butterfly_2x2 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1

//--- sim/ntt_ref_model.svh
`ifndef NTT_REF_MODEL_SVH
`define NTT_REF_MODEL_SVH

// --------------------------------------------------
// field arithmetic, plain 64-bit with % q
// --------------------------------------------------
typedef struct packed {
    coeff_t u;
    coeff_t v;
} pair_t;

function automatic coeff_t sum_mod(coeff_t a, coeff_t b);
    longint unsigned s;
    s = (64'(a) + 64'(b)) % 64'(NTT_Q);
    return coeff_t'(s);
endfunction

// bias by q so the difference stays positive
function automatic coeff_t diff_mod(coeff_t a, coeff_t b);
    longint unsigned d;
    d = (64'(a) + 64'(NTT_Q) - 64'(b)) % 64'(NTT_Q);
    return coeff_t'(d);
endfunction

function automatic coeff_t prod_mod(coeff_t a, coeff_t b);
    longint unsigned p;
    p = (64'(a) * 64'(b)) % 64'(NTT_Q);
    return coeff_t'(p);
endfunction

// divide by two as a multiply with the inverse
function automatic coeff_t half_mod(coeff_t a);
    return prod_mod(a, NTT_INV2);
endfunction

// ct: u + wv, u - wv; gs: (u+v)/2, w(u-v)/2
function automatic pair_t butterfly_pair(coeff_t u, coeff_t v, coeff_t w, logic inverse);
    pair_t  r;
    coeff_t t;
    if (inverse) begin
        r.u = half_mod(sum_mod(u, v));
        r.v = prod_mod(half_mod(diff_mod(u, v)), w);
    end else begin
        t   = prod_mod(w, v);
        r.u = sum_mod(u, t);
        r.v = diff_mod(u, t);
    end
    return r;
endfunction

// two stages, u outputs meet in bf10 and v outputs in bf11
function automatic bf_uv_t expected_ntt(ntt_operands_u op, logic inverse);
    pair_t  p00, p01, p10, p11;
    bf_uv_t r;
    p00 = butterfly_pair(op.bf.u00, op.bf.v00, op.bf.w00, inverse);
    p01 = butterfly_pair(op.bf.u01, op.bf.v01, op.bf.w01, inverse);
    p10 = butterfly_pair(p00.u, p01.u, op.bf.w10, inverse);
    p11 = butterfly_pair(p00.v, p01.v, op.bf.w11, inverse);
    r.u20 = p10.u;
    r.v20 = p10.v;
    r.u21 = p11.u;
    r.v21 = p11.v;
    return r;
endfunction

function automatic coeff_t lane_result(coeff_t u, coeff_t v, mode_t m);
    coeff_t r;
    case (m)
        pwm:     r = prod_mod(u, v);
        pwa:     r = sum_mod(u, v);
        default: r = diff_mod(u, v);
    endcase
    return r;
endfunction

function automatic pwo_uv_t expected_lanes(ntt_operands_u op, mode_t m);
    pwo_uv_t r;
    r.uv0 = lane_result(op.pwo.u0, op.pwo.v0, m);
    r.uv1 = lane_result(op.pwo.u1, op.pwo.v1, m);
    r.uv2 = lane_result(op.pwo.u2, op.pwo.v2, m);
    r.uv3 = lane_result(op.pwo.u3, op.pwo.v3, m);
    return r;
endfunction

`endif

//--- sim/tb_ntt_butterfly_2x2.sv
`timescale 1ns/1ps

module tb_ntt_butterfly_2x2;
    import ntt_pkg::*;

    `include "ntt_ref_model.svh"

    localparam int unsigned RES_W         = 4 * COEFF_W;
    localparam int unsigned RESET_CYCLES  = 5;
    // bursts plus the zeroized samples and the recovery bursts
    localparam int unsigned TOTAL_SAMPLES = 2 * 200 + 3 * 100 + 5 + 2 + 2 * 20;
    localparam int unsigned TIMEOUT_CYCLES = TOTAL_SAMPLES * 8 + 100;

    // pending result tagged with its issue cycle
    typedef struct packed {
        logic [RES_W-1:0] data;
        logic             lanes;
        int unsigned      issue_cycle;
    } expect_t;

    logic          clk = 1'b0;
    logic          reset_n;
    logic          zeroize;
    mode_t         mode;
    logic          enable;
    ntt_operands_u operands_i;
    bf_uv_t        uv_o;
    pwo_uv_t       pwo_o;
    logic          ready_o;

    expect_t     exp_q[$];
    int unsigned cycle_count = 0;

    ntt_butterfly_2x2 #(
        .REDUCE_Q (NTT_Q)
    ) UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .mode       (mode),
        .enable     (enable),
        .operands_i (operands_i),
        .uv_o       (uv_o),
        .pwo_o      (pwo_o),
        .ready_o    (ready_o)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // error reporting
    // --------------------------------------------------
    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string why);
        $display("error at %0t: %s", $time, why);
        stop_failed();
    endtask

    task automatic check_value(input logic [RES_W-1:0] got, input logic [RES_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // run limit on a free-running cycle count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error("simulation ran past its cycle limit, the DUT stopped responding");
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // uniform below q with an occasional edge value
    function automatic coeff_t rand_coeff();
        logic [31:0] r;
        coeff_t      c;
        r = $urandom;
        if (r[3:0] == 4'd0) begin
            case (r[5:4])
                2'd0:    c = '0;
                2'd1:    c = coeff_t'(1);
                default: c = NTT_Q - coeff_t'(1);
            endcase
        end else begin
            c = coeff_t'($urandom % 32'(NTT_Q));
        end
        return c;
    endfunction

    function automatic ntt_operands_u random_operands();
        logic [RES_W*2-1:0] word;
        for (int i = 0; i < 8; i++) begin
            word[i*COEFF_W +: COEFF_W] = rand_coeff();
        end
        return ntt_operands_u'(word);
    endfunction

    // compare outputs on each falling edge
    task automatic next_cycle();
        expect_t e;
        @(negedge clk);
        if (ready_o) begin
            if (exp_q.size() == 0) begin
                report_error("ready_o pulsed with no sample pending");
            end else begin
                e = exp_q.pop_front();
                check_value(RES_W'(cycle_count - e.issue_cycle),
                            e.lanes ? RES_W'(PWO_LATENCY) : RES_W'(NTT_LATENCY),
                            "ready latency");
                if (e.lanes) begin
                    check_value(pwo_o, e.data, "pwo_o lanes");
                end else begin
                    check_value(uv_o, e.data, "uv_o");
                end
            end
        end
    endtask

    // new operands every cycle and a model result for each enable
    task automatic drive_sample(input mode_t m, input logic en);
        expect_t e;
        mode       = m;
        operands_i = random_operands();
        enable     = en;
        if (en) begin
            e.lanes = m inside {pwm, pwa, pws};
            if (e.lanes) begin
                e.data = expected_lanes(operands_i, m);
            end else begin
                e.data = expected_ntt(operands_i, m == gs);
            end
            e.issue_cycle = cycle_count;
            exp_q.push_back(e);
        end
    endtask

    task automatic run_burst(input mode_t m, input int unsigned count);
        int unsigned sent;
        logic        en;
        sent = 0;
        while (sent < count) begin
            next_cycle();
            // about one cycle in four is a gap
            en = ($urandom % 4) != 0;
            drive_sample(m, en);
            if (en) begin
                sent++;
            end
        end
    endtask

    // longest pipeline empties before a mode change
    task automatic drain();
        next_cycle();
        enable = 1'b0;
        repeat (NTT_LATENCY + 3) next_cycle();
    endtask

    // zeroize n samples before any of them leaves
    task automatic zeroize_in_flight(input mode_t m, input int unsigned n);
        repeat (n) begin
            next_cycle();
            drive_sample(m, 1'b1);
        end
        next_cycle();
        enable  = 1'b0;
        zeroize = 1'b1;
        next_cycle();
        zeroize = 1'b0;
        // dropped samples never pulse
        exp_q.delete();
        repeat (NTT_LATENCY + 2) next_cycle();
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h9dea));
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        mode       = ct;
        operands_i = '0;
        repeat (RESET_CYCLES) next_cycle();
        reset_n = 1'b1;
        // ready_o stays low while idle after reset
        repeat (8) next_cycle();

        run_burst(ct, 200);
        drain();
        run_burst(gs, 200);
        drain();
        run_burst(pwm, 100);
        drain();
        run_burst(pwa, 100);
        drain();
        run_burst(pws, 100);
        drain();

        zeroize_in_flight(ct, 5);
        zeroize_in_flight(pwm, 2);
        // back to normal after the clear
        run_burst(ct, 20);
        drain();
        run_burst(pwa, 20);
        drain();

        if (exp_q.size() != 0) begin
            report_error("samples still pending at the end of the test");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- src/ntt_butterfly_2x2.sv
`timescale 1ns/1ps

module ntt_butterfly_2x2 #(
    parameter ntt_pkg::coeff_t REDUCE_Q = ntt_pkg::NTT_Q
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  ntt_pkg::mode_t         mode,
    input  logic                   enable,
    input  ntt_pkg::ntt_operands_u operands_i,
    output ntt_pkg::bf_uv_t        uv_o,
    output ntt_pkg::pwo_uv_t       pwo_o,
    output logic                   ready_o
);
    import ntt_pkg::*;

    // stage-2 twiddles wait out one butterfly
    localparam int TW_DEPTH = BF_LATENCY;

    logic pwo_mode;
    // stage-1 inputs
    coeff_t u00, v00, w00, u01, v01, w01;
    // stage-1 outputs
    coeff_t bf00_u, bf00_v, bf01_u, bf01_v;
    // stage-2 inputs
    coeff_t u10, v10, u11, v11;
    coeff_t [TW_DEPTH-1:0] w10_dly, w11_dly;

    assign pwo_mode = mode inside {pwm, pwa, pws};

    // --------------------------------------------------
    // twiddle delay line for stage 2
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly <= '0;
            w11_dly <= '0;
        end else if (zeroize) begin
            w10_dly <= '0;
            w11_dly <= '0;
        end else begin
            // enter at the top, leave at index 0
            w10_dly <= {operands_i.bf.w10, w10_dly[TW_DEPTH-1:1]};
            w11_dly <= {operands_i.bf.w11, w11_dly[TW_DEPTH-1:1]};
        end
    end

    // --------------------------------------------------
    // operand decode and stage routing
    // --------------------------------------------------
    always_comb begin
        if (pwo_mode) begin
            // lanes go straight into each butterfly
            u00 = operands_i.pwo.u0;
            v00 = operands_i.pwo.v0;
            u01 = operands_i.pwo.u1;
            v01 = operands_i.pwo.v1;
            u10 = operands_i.pwo.u2;
            v10 = operands_i.pwo.v2;
            u11 = operands_i.pwo.u3;
            v11 = operands_i.pwo.v3;
            // twiddles unused by lane ops
            w00 = '0;
            w01 = '0;
        end else begin
            u00 = operands_i.bf.u00;
            v00 = operands_i.bf.v00;
            w00 = operands_i.bf.w00;
            u01 = operands_i.bf.u01;
            v01 = operands_i.bf.v01;
            w01 = operands_i.bf.w01;
            // cross the u/v outputs between the two stages
            u10 = bf00_u;
            v10 = bf01_u;
            u11 = bf00_v;
            v11 = bf01_v;
        end
    end

    // stage 1
    ntt_butterfly #(.REDUCE_Q(REDUCE_Q)) bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .mode_i(mode),
        .u_i(u00), .v_i(v00), .w_i(w00),
        .u_o(bf00_u), .v_o(bf00_v), .pwo_o(pwo_o.uv0)
    );

    ntt_butterfly #(.REDUCE_Q(REDUCE_Q)) bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .mode_i(mode),
        .u_i(u01), .v_i(v01), .w_i(w01),
        .u_o(bf01_u), .v_o(bf01_v), .pwo_o(pwo_o.uv1)
    );

    // stage 2
    ntt_butterfly #(.REDUCE_Q(REDUCE_Q)) bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .mode_i(mode),
        .u_i(u10), .v_i(v10), .w_i(w10_dly[0]),
        .u_o(uv_o.u20), .v_o(uv_o.v20), .pwo_o(pwo_o.uv2)
    );

    ntt_butterfly #(.REDUCE_Q(REDUCE_Q)) bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .mode_i(mode),
        .u_i(u11), .v_i(v11), .w_i(w11_dly[0]),
        .u_o(uv_o.u21), .v_o(uv_o.v21), .pwo_o(pwo_o.uv3)
    );

    // result strobe
    ntt_ready_ctrl ready_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .enable_i  (enable),
        .mode_i    (mode),
        .ready_o   (ready_o)
    );

endmodule

//--- src/ntt_ready_ctrl.sv
`timescale 1ns/1ps

module ntt_ready_ctrl (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize_i,
    input  logic           enable_i,
    input  ntt_pkg::mode_t mode_i,
    output logic           ready_o
);
    import ntt_pkg::*;

    // one bit per cycle in flight, bit 0 is the exit
    logic [NTT_LATENCY-1:0] ready_sr;
    logic [NTT_LATENCY-1:0] ready_nxt;
    logic                   ntt_mode;

    // two butterfly stages for ct/gs, one for lanes
    assign ntt_mode = (mode_i == ct) || (mode_i == gs);

    // --------------------------------------------------
    // shift toward bit 0, insert enable by mode
    // --------------------------------------------------
    always_comb begin
        ready_nxt = ready_sr >> 1;
        if (ntt_mode) begin
            // top bit is empty after the shift
            ready_nxt[NTT_LATENCY-1] = enable_i;
        end else begin
            // keep any pulse already passing this depth
            ready_nxt[PWO_LATENCY-1] = ready_sr[PWO_LATENCY] | enable_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= '0;
        end else if (zeroize_i) begin
            // pending pulses are dropped
            ready_sr <= '0;
        end else begin
            ready_sr <= ready_nxt;
        end
    end

    // high in the same cycle the last butterfly stage presents data
    assign ready_o = ready_sr[0];

endmodule

//--- src/ntt_butterfly.sv
`timescale 1ns/1ps

module ntt_butterfly #(
    parameter ntt_pkg::coeff_t REDUCE_Q = ntt_pkg::NTT_Q
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::mode_t  mode_i,
    input  ntt_pkg::coeff_t u_i,
    input  ntt_pkg::coeff_t v_i,
    input  ntt_pkg::coeff_t w_i,
    output ntt_pkg::coeff_t u_o,
    output ntt_pkg::coeff_t v_o,
    output ntt_pkg::coeff_t pwo_o
);
    import ntt_pkg::*;

    // (a + b) mod q, both inputs below q
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, REDUCE_Q}) begin
            s = s - {1'b0, REDUCE_Q};
        end
        return s[COEFF_W-1:0];
    endfunction

    // (a - b) mod q, biased by q so it never goes negative
    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        logic [COEFF_W:0] d;
        d = {1'b0, a} + {1'b0, REDUCE_Q} - {1'b0, b};
        if (d >= {1'b0, REDUCE_Q}) begin
            d = d - {1'b0, REDUCE_Q};
        end
        return d[COEFF_W-1:0];
    endfunction

    // a * inv2 mod q: make it even by adding q, then shift
    function automatic coeff_t halve(coeff_t a);
        logic [COEFF_W:0] h;
        h = a[0] ? ({1'b0, a} + {1'b0, REDUCE_Q}) : {1'b0, a};
        return h[COEFF_W:1];
    endfunction

    logic   is_ct, is_gs, is_pwm;
    coeff_t add_c, sub_c;
    coeff_t s1_a_nxt;
    // u path: ct u, gs half sum, pwa/pws result
    coeff_t s1_a, s2_a;
    // gs half difference and its twiddle, one cycle in
    coeff_t s1_b, w_d;
    coeff_t mul_a, mul_b, mul_p;
    coeff_t v_q;

    assign is_ct  = (mode_i == ct);
    assign is_gs  = (mode_i == gs);
    assign is_pwm = (mode_i == pwm);

    assign add_c = mod_add(u_i, v_i);
    assign sub_c = mod_sub(u_i, v_i);

    always_comb begin
        unique case (mode_i)
            ct:      s1_a_nxt = u_i;
            gs:      s1_a_nxt = halve(add_c);
            pws:     s1_a_nxt = sub_c;
            default: s1_a_nxt = add_c;
        endcase
    end

    // --------------------------------------------------
    // stages 1 and 2, multiplier runs alongside
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_a <= '0;
            s1_b <= '0;
            w_d  <= '0;
            s2_a <= '0;
        end else if (zeroize_i) begin
            s1_a <= '0;
            s1_b <= '0;
            w_d  <= '0;
            s2_a <= '0;
        end else begin
            s1_a <= s1_a_nxt;
            s1_b <= halve(sub_c);
            w_d  <= w_i;
            s2_a <= s1_a;
        end
    end

    // ct w*v and pwm u*v start at cycle 0, gs diff*w at cycle 1
    assign mul_a = is_gs ? s1_b : (is_ct ? w_i : u_i);
    assign mul_b = is_gs ? w_d : v_i;

    ntt_mod_mult #(
        .REDUCE_Q (REDUCE_Q)
    ) mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (mul_p)
    );

    // --------------------------------------------------
    // stage 3: ct add/sub, lane results out
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_o   <= '0;
            v_q   <= '0;
            pwo_o <= '0;
        end else if (zeroize_i) begin
            u_o   <= '0;
            v_q   <= '0;
            pwo_o <= '0;
        end else begin
            u_o   <= is_ct ? mod_add(s2_a, mul_p) : s2_a;
            v_q   <= mod_sub(s2_a, mul_p);
            pwo_o <= is_pwm ? mul_p : s2_a;
        end
    end

    // gs product lands in the same cycle as the ct difference
    assign v_o = is_gs ? mul_p : v_q;

endmodule

//--- src/ntt_mod_mult.sv
`timescale 1ns/1ps

module ntt_mod_mult #(
    parameter ntt_pkg::coeff_t REDUCE_Q = ntt_pkg::NTT_Q
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);
    import ntt_pkg::*;

    // full 46-bit product, registered in cycle 1
    logic [2*COEFF_W-1:0] prod_q;
    // remainder of the registered product
    logic [2*COEFF_W-1:0] prod_red;

    // --------------------------------------------------
    // cycle 1: raw multiply
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
        end else begin
            // widen before multiply so no bits drop
            prod_q <= (2*COEFF_W)'(a_i) * (2*COEFF_W)'(b_i);
        end
    end

    // --------------------------------------------------
    // cycle 2: reduce mod q
    // --------------------------------------------------
    // operands below q keep the product below q^2
    assign prod_red = prod_q % (2*COEFF_W)'(REDUCE_Q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p_o <= '0;
        end else if (zeroize_i) begin
            p_o <= '0;
        end else begin
            // remainder fits one coefficient
            p_o <= prod_red[COEFF_W-1:0];
        end
    end

endmodule

//--- src/ntt_pkg.sv
package ntt_pkg;

    // --------------------------------------------------
    // ml-dsa field and datapath widths
    // --------------------------------------------------
    localparam int unsigned COEFF_W = 23;

    // q = 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] NTT_Q    = 23'd8380417;
    // (q+1)/2, inverse of 2 mod q for gs halving
    localparam logic [COEFF_W-1:0] NTT_INV2 = 23'd4190209;

    // pipeline depths in clock edges
    localparam int unsigned MULT_LATENCY = 2;
    localparam int unsigned BF_LATENCY   = 3;
    localparam int unsigned NTT_LATENCY  = 2 * BF_LATENCY;
    localparam int unsigned PWO_LATENCY  = BF_LATENCY;

    typedef logic [COEFF_W-1:0] coeff_t;

    // ct = forward layer, gs = inverse layer, rest are lane ops
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    // --------------------------------------------------
    // operand word, two views of the same 184 bits
    // --------------------------------------------------
    // stage-1 pairs plus stage-2 twiddles
    typedef struct packed {
        coeff_t u00, v00, w00;
        coeff_t u01, v01, w01;
        coeff_t w10, w11;
    } bf_operands_t;

    // four independent lanes
    typedef struct packed {
        coeff_t u0, v0;
        coeff_t u1, v1;
        coeff_t u2, v2;
        coeff_t u3, v3;
    } pwo_operands_t;

    typedef union packed {
        bf_operands_t  bf;
        pwo_operands_t pwo;
    } ntt_operands_u;

    // stage-2 results
    typedef struct packed {
        coeff_t u20, v20;
        coeff_t u21, v21;
    } bf_uv_t;

    // lane results, uv0 from bf00 through uv3 from bf11
    typedef struct packed {
        coeff_t uv0, uv1, uv2, uv3;
    } pwo_uv_t;

endpackage
